// File: dv/mmu_tb.sv
`timescale 1ns/1ps
`include "mmu_macros.svh"

module mmu_tb
	import mmu_pkg::*;
();

	localparam int NUM_TESTS = 6;
	// Attribute sweep dominates the run time
	localparam int ATTR_ACCESSES = 4 * 8 * 8 * 4;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + ATTR_ACCESSES * 3;
	localparam int WB_TIMEOUT = 8;
	localparam int RSP_TIMEOUT = 6;

	logic clk;
	logic reset;
	logic req_valid;
	mmu_req_t req;
	logic rsp_valid;
	mmu_rsp_t rsp;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [7:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [3:0] wb_sel;
	logic [31:0] wb_dat_r;
	logic wb_ack;

	int errors;

	// Shadow copy of what has been written over the bus
	logic model_v [`MMU_TLB_ENTRIES];
	logic [19:0] model_vpn [`MMU_TLB_ENTRIES];
	logic [31:0] model_pte [`MMU_TLB_ENTRIES];
	logic [31:0] model_reg [`MMU_REGIONS];

	mmu_top DUT
	(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_sel(wb_sel),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	always #50 clk = ~clk;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
		begin
			errors++;
			$display("ERROR: %s is %h, expected %h at %0t", name, got, want, $time);
		end
	endtask

	// Privilege and attribute rules, one term per rule
	function automatic logic expected_priv_err(logic id, logic we, cpl_t cpl, int om,
			cpl_t pl, logic u, rwx_t tlb_rwx, rwx_t reg_rwx);
		logic app;
		logic app_sup;
		logic no_sec;
		logic err;
		app = (om == 0);
		app_sup = (om <= 1);
		no_sec = (om != 3);
		err = 1'b0;
		err |= app_sup && !id && (cpl < pl);
		err |= app_sup && id && (cpl >= pl);
		err |= no_sec && id && we;
		err |= we && reg_rwx[2];
		err |= app_sup && !id && reg_rwx[0];
		err |= app && !u;
		err |= app_sup && we && (tlb_rwx[2:1] == 2'b10);
		err |= app_sup && !id && tlb_rwx[0];
		return err;
	endfunction

	function automatic mmu_rsp_t expect_rsp(mmu_req_t r);
		mmu_rsp_t e;
		int hit;
		logic [31:0] pw;
		rwx_t reg_rwx;
		e = '0;
		hit = -1;
		// Lowest valid matching entry
		for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--)
		begin
			if (model_v[i] && (model_vpn[i] == r.vadr[31:12]))
				hit = i;
		end
		if (hit < 0)
		begin
			e.miss = 1'b1;
			return e;
		end
		pw = model_pte[hit];
		e.padr = {pw[31:12], r.vadr[11:0]};
		reg_rwx = model_reg[e.padr[31:29]][3 * int'(r.om) +: 3];
		e.priv_err = expected_priv_err(r.id, r.we, r.cpl, int'(r.om), pw[11:4], pw[3],
			pw[2:0], reg_rwx);
		return e;
	endfunction

	// pte word: ppn 31:12, pl 11:4, u 3, rwx 2:0
	function automatic logic [31:0] make_pte(logic [19:0] ppn, cpl_t pl, logic u, rwx_t rwx);
		return {ppn, pl, u, rwx};
	endfunction

	// Starts and ends on a falling edge
	task automatic wb_transfer(input logic write, input logic [7:0] adr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = write;
		wb_adr = adr;
		wb_dat_w = wdata;
		wb_sel = 4'hf;
		waited = 0;
		rdata = '0;
		do
		begin
			@(negedge clk);
			waited++;
		end
		while (!wb_ack && waited < WB_TIMEOUT);
		if (!wb_ack)
		begin
			errors++;
			$display("Wishbone access to address %h got no ack", adr);
		end
		else
		begin
			rdata = wb_dat_r;
			// Write commits on the edge that ends the ack cycle
			if (write)
				@(negedge clk);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input logic [7:0] adr, input logic [31:0] data);
		logic [31:0] unused_rd;
		wb_transfer(1'b1, adr, data, unused_rd);
	endtask

	task automatic wb_read(input logic [7:0] adr, output logic [31:0] data);
		wb_transfer(1'b0, adr, 32'h0, data);
	endtask

	task automatic set_tlb(input int idx, input logic v, input logic [19:0] vpn,
			input logic [31:0] pte);
		wb_write(8'(`MMU_WB_TLB_BASE + 2 * idx), {v, 11'b0, vpn});
		wb_write(8'(`MMU_WB_TLB_BASE + 2 * idx + 1), pte);
		model_v[idx] = v;
		model_vpn[idx] = vpn;
		model_pte[idx] = pte;
	endtask

	task automatic set_region(input int idx, input logic [31:0] word);
		wb_write(8'(`MMU_WB_REG_BASE + idx), word);
		model_reg[idx] = word;
	endtask

	task automatic compare_rsp(input mmu_rsp_t want);
		check("rsp.padr", rsp.padr, want.padr);
		check("rsp.miss", rsp.miss, want.miss);
		check("rsp.priv_err", rsp.priv_err, want.priv_err);
	endtask

	// One request, then wait for its response
	task automatic access(input vadr_t vadr, input logic id, input logic we, input cpl_t cpl,
			input operating_mode_t om);
		mmu_rsp_t want;
		int cycles;
		logic seen;
		req.vadr = vadr;
		req.id = id;
		req.we = we;
		req.cpl = cpl;
		req.om = om;
		req_valid = 1'b1;
		want = expect_rsp(req);
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < RSP_TIMEOUT)
		begin
			@(negedge clk);
			req_valid = 1'b0;
			cycles++;
			seen = rsp_valid;
		end
		if (!seen)
		begin
			errors++;
			$display("No response to the request for vadr %h", vadr);
		end
		else
		begin
			check("rsp_valid latency", cycles, 2);
			compare_rsp(want);
		end
	endtask

	task automatic test_reset_readback();
		logic [31:0] rd;
		logic [31:0] pw;
		logic [19:0] vpn;
		logic [7:0] unmapped [4] = '{8'h10, 8'h1f, 8'h28, 8'hff};
		// Tables as reset leaves them
		for (int i = 0; i < `MMU_TLB_ENTRIES; i++)
			model_v[i] = 1'b0;
		for (int i = 0; i < `MMU_REGIONS; i++)
			model_reg[i] = 32'h0;
		// No entry valid yet
		for (int i = 0; i < 8; i++)
		begin
			access($urandom, 1'($urandom), 1'b0, 8'($urandom), OM_APP);
			check("rsp.miss", rsp.miss, 1'b1);
		end
		// Distinct vpns by the low bits
		for (int i = 0; i < `MMU_TLB_ENTRIES; i++)
		begin
			vpn = {17'($urandom), 3'(i)};
			pw = $urandom;
			set_tlb(i, 1'b1, vpn, pw);
			wb_read(8'(`MMU_WB_TLB_BASE + 2 * i), rd);
			check("tlb vpn word", rd, {1'b1, 11'b0, vpn});
			wb_read(8'(`MMU_WB_TLB_BASE + 2 * i + 1), rd);
			check("tlb pte word", rd, pw);
		end
		for (int i = 0; i < `MMU_REGIONS; i++)
		begin
			// Attributes come up clear
			wb_read(8'(`MMU_WB_REG_BASE + i), rd);
			check("region reset word", rd, 32'h0);
			pw = {20'h0, 12'($urandom)};
			set_region(i, pw);
			wb_read(8'(`MMU_WB_REG_BASE + i), rd);
			check("region word", rd, pw);
		end
		// Unmapped space swallows writes
		wb_write(8'h28, 32'hffffffff);
		foreach (unmapped[k])
		begin
			wb_read(unmapped[k], rd);
			check("unmapped dat_r", rd, 32'h0);
		end
		wb_read(8'(`MMU_WB_REG_BASE), rd);
		check("region word", rd, model_reg[0]);
		// Empty tables for the next tests
		for (int i = 0; i < `MMU_TLB_ENTRIES; i++)
		begin
			set_tlb(i, 1'b0, 20'h0, 32'h0);
			set_region(i, 32'h0);
		end
	endtask

	task automatic test_translation();
		for (int i = 0; i < 4; i++)
			set_tlb(i, 1'b1, 20'h10000 + 20'(i), make_pte(20'($urandom), 8'h00, 1'b1, 3'b000));
		for (int k = 0; k < 16; k++)
		begin
			access({20'h10000 + 20'(k % 4), 12'($urandom)}, 1'b0, 1'b0, 8'h00, OM_SUPERVISOR);
			check("rsp.miss", rsp.miss, 1'b0);
		end
		// Page never loaded
		access({20'h20000, 12'($urandom)}, 1'b0, 1'b0, 8'h00, OM_APP);
		check("rsp.miss", rsp.miss, 1'b1);
		check("rsp.padr", rsp.padr, 32'h0);
		check("rsp.priv_err", rsp.priv_err, 1'b0);
	endtask

	task automatic test_privilege();
		cpl_t cpls [5] = '{8'h00, 8'h3f, 8'h40, 8'h41, 8'hff};
		for (int u = 0; u < 2; u++)
		begin
			// Region 0, attributes all clear
			set_tlb(4, 1'b1, 20'h10004, make_pte({3'd0, 17'($urandom)}, 8'h40, 1'(u), 3'b000));
			for (int m = 0; m < 2; m++)
				for (int id = 0; id < 2; id++)
					for (int c = 0; c < 5; c++)
						access({20'h10004, 12'($urandom)}, 1'(id), 1'b0, cpls[c],
							operating_mode_t'(m));
		end
	endtask

	task automatic test_attributes();
		for (int t = 0; t < 8; t++)
		begin
			set_tlb(5, 1'b1, 20'h10005, make_pte({3'd5, 17'($urandom)}, 8'h80, 1'b1, 3'(t)));
			for (int g = 0; g < 8; g++)
			begin
				// Different rwx per mode, each mode still sees all eight values
				set_region(5, {20'h0, 3'(g + 3), 3'(g + 2), 3'(g + 1), 3'(g)});
				for (int m = 0; m < 4; m++)
					for (int w = 0; w < 2; w++)
						for (int id = 0; id < 2; id++)
							access({20'h10005, 12'($urandom)}, 1'(id), 1'(w), 8'h80,
								operating_mode_t'(m));
			end
		end
	endtask

	task automatic test_pipeline();
		mmu_req_t reqs[$];
		mmu_rsp_t want_q[$];
		mmu_req_t r;
		logic [19:0] vpn;
		for (int k = 0; k < 12; k++)
		begin
			// Every third request misses
			if (k % 3 == 2)
				vpn = 20'h30000 + 20'(k);
			else
				vpn = 20'h10000 + 20'($urandom_range(0, 5));
			r.vadr = {vpn, 12'($urandom)};
			r.id = 1'($urandom);
			r.we = 1'($urandom);
			r.cpl = 8'($urandom);
			r.om = operating_mode_t'(2'($urandom));
			reqs.push_back(r);
		end
		for (int k = 0; k < 14; k++)
		begin
			if (k >= 2)
			begin
				check("rsp_valid", rsp_valid, 1'b1);
				compare_rsp(want_q.pop_front());
			end
			if (k < 12)
			begin
				req = reqs[k];
				req_valid = 1'b1;
				want_q.push_back(expect_rsp(reqs[k]));
			end
			else
				req_valid = 1'b0;
			@(negedge clk);
		end
		check("rsp_valid", rsp_valid, 1'b0);
	endtask

	task automatic test_live_update();
		vadr_t va;
		va = {20'h10006, 12'($urandom)};
		set_tlb(6, 1'b1, 20'h10006, make_pte({3'd0, 17'($urandom)}, 8'h10, 1'b1, 3'b000));
		access(va, 1'b0, 1'b0, 8'h20, OM_APP);
		// New frame and a supervisor page
		model_pte[6] = make_pte({3'd0, 17'($urandom)}, 8'h10, 1'b0, 3'b000);
		wb_write(8'(`MMU_WB_TLB_BASE + 2 * 6 + 1), model_pte[6]);
		access(va, 1'b0, 1'b0, 8'h20, OM_APP);
		check("rsp.priv_err", rsp.priv_err, 1'b1);
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_sel = '0;
		errors = 0;
		void'($urandom(32'hb210));
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset_readback();
		test_translation();
		test_privilege();
		test_attributes();
		test_pipeline();
		test_live_update();
		$display("%0d errors", errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Hang guard
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Run did not complete within %0d cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

endmodule

// File: hdl/mmu_attr_check.sv
`timescale 1ns/1ps

module mmu_attr_check
	import mmu_pkg::*;
(
	// Instruction fetch when set, data access when clear
	input logic id,
	input cpl_t cpl,
	input tlb_entry_t tlb_entry,
	input operating_mode_t om,
	input logic we,
	input region_t region,
	output logic priv_err
);

	logic app_mode;
	logic app_sup;
	logic non_secure;
	rwx_t reg_rwx;
	rwx_t tlb_rwx;

	// Mode groups that the rules apply to
	assign app_mode = (om == OM_APP);
	assign app_sup = (om == OM_APP) || (om == OM_SUPERVISOR);
	assign non_secure = (om != OM_SECURE);

	// Region attributes for the current mode
	assign reg_rwx = region.at[om];
	assign tlb_rwx = tlb_entry.pte.rwx;

	always_comb
	begin
		priv_err = 1'b0;
		// Data access needs cpl at or above the page level
		if (app_sup && !id && (cpl < tlb_entry.pte.pl))
			priv_err = 1'b1;
		// Fetch needs a more privileged level than the page
		if (app_sup && id && (cpl >= tlb_entry.pte.pl))
			priv_err = 1'b1;
		// Fetch that also writes
		if (non_secure && id && we)
			priv_err = 1'b1;

		// Region write protect applies in every mode
		if (we && reg_rwx[2])
			priv_err = 1'b1;
		// Region marked executable, no data access
		if (app_sup && !id && reg_rwx[0])
			priv_err = 1'b1;

		// Application code only touches user pages
		if (app_mode && !tlb_entry.pte.u)
			priv_err = 1'b1;
		// Read-only page
		if (app_sup && we && (tlb_rwx[2:1] == 2'b10))
			priv_err = 1'b1;
		// Executable page, no data access
		if (app_sup && !id && tlb_rwx[0])
			priv_err = 1'b1;
	end

	// Known mode and known inputs give a known verdict
	always_comb
	begin
		if (!$isunknown(om))
		begin
			a_priv_err_known: assert (!$isunknown(priv_err))
				else $error("priv_err unknown with om %0d", om);
		end
	end

endmodule

// File: hdl/mmu_cfg_wb.sv
`timescale 1ns/1ps
`include "mmu_macros.svh"

module mmu_cfg_wb
	import mmu_pkg::*;
(
	input logic clk,
	input logic reset,
	// Wishbone classic slave
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [7:0] adr,
	input logic [31:0] dat_w,
	input logic [3:0] sel,
	output logic [31:0] dat_r,
	output logic ack,
	// Storage side
	output logic tlb_wr,
	output tlb_idx_t tlb_wr_idx,
	output logic tlb_wr_hi,
	output logic reg_wr,
	output reg_idx_t reg_wr_idx,
	output logic [31:0] cfg_wdata,
	input logic [31:0] tlb_rdata,
	input logic [31:0] reg_rdata
);

	localparam int TLB_IDX_W = $bits(tlb_idx_t);
	localparam int REG_IDX_W = $bits(reg_idx_t);

	logic [7:0] tlb_ofs;
	logic [7:0] reg_ofs;
	logic in_tlb;
	logic in_reg;
	logic wr_stb;

	// Window decode by offset from each base
	assign tlb_ofs = adr - `MMU_WB_TLB_BASE;
	assign reg_ofs = adr - `MMU_WB_REG_BASE;
	assign in_tlb = (tlb_ofs < 8'(2 * `MMU_TLB_ENTRIES));
	assign in_reg = (reg_ofs < 8'(`MMU_REGIONS));

	// Indices also steer the read-back muxes in the storage blocks
	assign tlb_wr_idx = tlb_ofs[TLB_IDX_W:1];
	assign tlb_wr_hi = tlb_ofs[0];
	assign reg_wr_idx = reg_ofs[REG_IDX_W-1:0];

	// One ack per access, the cycle after cyc and stb are seen
	always_ff @(posedge clk)
	begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= cyc && stb && !ack;
	end

	// Commit in the ack cycle
	// Partial byte selects still write the whole word
	// An empty select is a no-op
	assign wr_stb = ack && cyc && stb && we && (|sel);
	assign tlb_wr = wr_stb && in_tlb;
	assign reg_wr = wr_stb && in_reg;
	assign cfg_wdata = dat_w;

	// Unmapped space reads zero
	always_comb
	begin
		if (in_tlb)
			dat_r = tlb_rdata;
		else if (in_reg)
			dat_r = reg_rdata;
		else
			dat_r = '0;
	end

	a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
		ack |=> !ack)
		else $error("ack held for two cycles");

endmodule

// File: hdl/mmu_pkg.sv
`include "mmu_macros.svh"

package mmu_pkg;

	// Addresses
	typedef logic [31:0] vadr_t;
	typedef logic [31:0] padr_t;

	// Page numbers and page offset
	typedef logic [31-`MMU_PAGE_BITS:0] vpn_t;
	typedef logic [31-`MMU_PAGE_BITS:0] ppn_t;
	typedef logic [`MMU_PAGE_BITS-1:0] pg_ofs_t;

	// Privilege level, lower value is more privileged
	typedef logic [7:0] cpl_t;

	// Attribute bits
	typedef logic [2:0] rwx_t;

	// Table indices
	typedef logic [$clog2(`MMU_TLB_ENTRIES)-1:0] tlb_idx_t;
	typedef logic [$clog2(`MMU_REGIONS)-1:0] reg_idx_t;

	typedef enum logic [1:0]
	{
		OM_APP = 2'd0,
		OM_SUPERVISOR = 2'd1,
		OM_HYPERVISOR = 2'd2,
		OM_SECURE = 2'd3
	} operating_mode_t;

	// Low 32 bits are the pte word on the bus
	// The valid bit does not fit there, it sits in bit 31 of the vpn word
	typedef struct packed
	{
		logic v;
		ppn_t ppn;
		cpl_t pl;
		logic u;
		rwx_t rwx;
	} pte_t;

	typedef struct packed
	{
		vpn_t vpn;
		pte_t pte;
	} tlb_entry_t;

	// One rwx field per operating mode, low 12 bits of the region word
	typedef struct packed
	{
		rwx_t [3:0] at;
	} region_t;

	typedef struct packed
	{
		vadr_t vadr;
		logic id;
		logic we;
		cpl_t cpl;
		operating_mode_t om;
	} mmu_req_t;

	typedef struct packed
	{
		padr_t padr;
		logic miss;
		logic priv_err;
	} mmu_rsp_t;

endpackage

// File: hdl/mmu_region_table.sv
`timescale 1ns/1ps
`include "mmu_macros.svh"

module mmu_region_table
	import mmu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic reg_wr,
	input reg_idx_t reg_wr_idx,
	input logic [31:0] cfg_wdata,
	input reg_idx_t rd_idx,
	output logic [31:0] reg_rdata,
	input padr_t padr,
	output region_t region
);

	localparam int REG_W = $bits(region_t);
	localparam int IDX_W = $bits(reg_idx_t);

	region_t regions_q [`MMU_REGIONS];
	reg_idx_t lookup_idx;

	// Attributes come up all clear
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `MMU_REGIONS; i++)
				regions_q[i] <= '0;
		end
		else if (reg_wr)
		begin
			regions_q[reg_wr_idx] <= region_t'(cfg_wdata[REG_W-1:0]);
		end
	end

	// Region picked by the top physical address bits
	assign lookup_idx = padr[31 -: IDX_W];
	assign region = regions_q[lookup_idx];

	// Read-back, upper bits read zero
	assign reg_rdata = {{(32-REG_W){1'b0}}, regions_q[rd_idx]};

endmodule

// File: hdl/mmu_tlb.sv
`timescale 1ns/1ps
`include "mmu_macros.svh"

module mmu_tlb
	import mmu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic req_valid,
	input mmu_req_t req,
	// Configuration side
	input logic tlb_wr,
	input tlb_idx_t tlb_wr_idx,
	input logic tlb_wr_hi,
	input logic [31:0] cfg_wdata,
	input tlb_idx_t rd_idx,
	input logic rd_hi,
	output logic [31:0] tlb_rdata,
	// Stage one
	output logic s1_valid,
	output mmu_req_t s1_req,
	output logic s1_hit,
	output tlb_entry_t s1_entry
);

	localparam int VPN_W = $bits(vpn_t);

	// Entry storage, only the valid bits are reset
	logic [`MMU_TLB_ENTRIES-1:0] v_q;
	vpn_t vpn_q [`MMU_TLB_ENTRIES];
	logic [31:0] pte_q [`MMU_TLB_ENTRIES];

	tlb_entry_t entries [`MMU_TLB_ENTRIES];
	logic [`MMU_TLB_ENTRIES-1:0] match;
	tlb_idx_t hit_idx;
	logic hit;
	vpn_t req_vpn;

	always_ff @(posedge clk)
	begin
		if (reset)
			v_q <= '0;
		else if (tlb_wr && !tlb_wr_hi)
			v_q[tlb_wr_idx] <= cfg_wdata[31];
	end

	// Low word carries the vpn, high word the pte body
	always_ff @(posedge clk)
	begin
		if (tlb_wr && !tlb_wr_hi)
			vpn_q[tlb_wr_idx] <= cfg_wdata[VPN_W-1:0];
		if (tlb_wr && tlb_wr_hi)
			pte_q[tlb_wr_idx] <= cfg_wdata;
	end

	// Read-back in bus layout
	assign tlb_rdata = rd_hi ? pte_q[rd_idx]
		: {v_q[rd_idx], {(31-VPN_W){1'b0}}, vpn_q[rd_idx]};

	// Reassemble full entries with the valid bit
	always_comb
	begin
		for (int i = 0; i < `MMU_TLB_ENTRIES; i++)
		begin
			entries[i].vpn = vpn_q[i];
			entries[i].pte = pte_t'({v_q[i], pte_q[i]});
		end
	end

	assign req_vpn = req.vadr[31 -: VPN_W];

	// Parallel compare against every valid entry
	always_comb
	begin
		for (int i = 0; i < `MMU_TLB_ENTRIES; i++)
			match[i] = v_q[i] && (vpn_q[i] == req_vpn);
	end

	// Lowest matching index wins
	always_comb
	begin
		hit_idx = '0;
		for (int i = `MMU_TLB_ENTRIES-1; i >= 0; i--)
		begin
			if (match[i])
				hit_idx = tlb_idx_t'(i);
		end
	end

	assign hit = |match;

	always_ff @(posedge clk)
	begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= req_valid;
	end

	// Stage one payload
	always_ff @(posedge clk)
	begin
		s1_req <= req;
		s1_hit <= hit;
		s1_entry <= entries[hit_idx];
	end

	// Distinct vpns give at most one hit, switch off when loading aliases on purpose
	a_tlb_one_hit: assert property (@(posedge clk) disable iff (reset)
		req_valid |-> ($countones(match) <= 1))
		else $error("multiple TLB hits for vpn %h", req_vpn);

endmodule

// File: hdl/mmu_top.sv
`timescale 1ns/1ps

module mmu_top
	import mmu_pkg::*;
(
	input logic clk,
	input logic reset,
	// Access port, no back-pressure
	input logic req_valid,
	input mmu_req_t req,
	output logic rsp_valid,
	output mmu_rsp_t rsp,
	// Configuration port
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [7:0] wb_adr,
	input logic [31:0] wb_dat_w,
	input logic [3:0] wb_sel,
	output logic [31:0] wb_dat_r,
	output logic wb_ack
);

	logic tlb_wr;
	tlb_idx_t tlb_wr_idx;
	logic tlb_wr_hi;
	logic reg_wr;
	reg_idx_t reg_wr_idx;
	logic [31:0] cfg_wdata;
	logic [31:0] tlb_rdata;
	logic [31:0] reg_rdata;

	logic s1_valid;
	mmu_req_t s1_req;
	logic s1_hit;
	tlb_entry_t s1_entry;

	padr_t s2_padr;
	region_t s2_region;
	logic chk_err;
	mmu_rsp_t rsp_d;

	mmu_cfg_wb u_cfg
	(
		.clk(clk),
		.reset(reset),
		.cyc(wb_cyc),
		.stb(wb_stb),
		.we(wb_we),
		.adr(wb_adr),
		.dat_w(wb_dat_w),
		.sel(wb_sel),
		.dat_r(wb_dat_r),
		.ack(wb_ack),
		.tlb_wr(tlb_wr),
		.tlb_wr_idx(tlb_wr_idx),
		.tlb_wr_hi(tlb_wr_hi),
		.reg_wr(reg_wr),
		.reg_wr_idx(reg_wr_idx),
		.cfg_wdata(cfg_wdata),
		.tlb_rdata(tlb_rdata),
		.reg_rdata(reg_rdata)
	);

	// Decoded bus address doubles as the read-back index
	mmu_tlb u_tlb
	(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.tlb_wr(tlb_wr),
		.tlb_wr_idx(tlb_wr_idx),
		.tlb_wr_hi(tlb_wr_hi),
		.cfg_wdata(cfg_wdata),
		.rd_idx(tlb_wr_idx),
		.rd_hi(tlb_wr_hi),
		.tlb_rdata(tlb_rdata),
		.s1_valid(s1_valid),
		.s1_req(s1_req),
		.s1_hit(s1_hit),
		.s1_entry(s1_entry)
	);

	// Stage two physical address
	assign s2_padr = s1_hit ? {s1_entry.pte.ppn, pg_ofs_t'(s1_req.vadr)} : '0;

	mmu_region_table u_region
	(
		.clk(clk),
		.reset(reset),
		.reg_wr(reg_wr),
		.reg_wr_idx(reg_wr_idx),
		.cfg_wdata(cfg_wdata),
		.rd_idx(reg_wr_idx),
		.reg_rdata(reg_rdata),
		.padr(s2_padr),
		.region(s2_region)
	);

	mmu_attr_check u_check
	(
		.id(s1_req.id),
		.cpl(s1_req.cpl),
		.tlb_entry(s1_entry),
		.om(s1_req.om),
		.we(s1_req.we),
		.region(s2_region),
		.priv_err(chk_err)
	);

	// A miss reports no privilege error
	assign rsp_d.padr = s2_padr;
	assign rsp_d.miss = !s1_hit;
	assign rsp_d.priv_err = s1_hit && chk_err;

	always_ff @(posedge clk)
	begin
		if (reset)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= s1_valid;
	end

	// Response payload holds between valid cycles
	always_ff @(posedge clk)
	begin
		if (s1_valid)
			rsp <= rsp_d;
	end

endmodule

// File: include/mmu_macros.svh
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// Translation geometry
`define MMU_TLB_ENTRIES 8
`define MMU_REGIONS 8

// 4 KiB pages
`define MMU_PAGE_BITS 12

// Wishbone word address map
// TLB window holds two words per entry, vpn word then pte word
`define MMU_WB_TLB_BASE 8'h00

// Region window holds one attribute word per region
`define MMU_WB_REG_BASE 8'h20

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the MMU testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module mmu_tb -o mmu_sim \
	&& ./obj_dir/mmu_sim > sim.log 2>&1 \
	|| { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^Finished with no errors$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: src.f
+incdir+include
hdl/mmu_pkg.sv
hdl/mmu_attr_check.sv
hdl/mmu_tlb.sv
hdl/mmu_region_table.sv
hdl/mmu_cfg_wb.sv
hdl/mmu_top.sv
dv/mmu_tb.sv
